/* compile.f */
+incdir+include
hw/issue_pkg.sv
hw/dec_pair_if.sv
hw/inst_decoder.sv
hw/issue_buffer.sv
hw/issue_select.sv
hw/issue_top.sv
testbench/issue_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module issue_tb -o issue_sim &&
./obj_dir/issue_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }

/* testbench/issue_tb.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_tb import issue_pkg::*; ();

    // LoongArch encodings, 3r opcode in bits 31:15, 2ri12 opcode in bits 31:22
    localparam logic [16:0] ADD_W    = 17'h00020;
    localparam logic [16:0] SUB_W    = 17'h00022;
    localparam logic [16:0] AND_R    = 17'h00029;
    localparam logic [16:0] OR_R     = 17'h0002a;
    localparam logic [9:0]  ADDI_W   = 10'h00a;
    localparam logic [9:0]  LD_W     = 10'h0a2;
    localparam logic [9:0]  ST_W     = 10'h0a6;
    localparam logic [31:0] BAD_WORD = 32'hfc001234;    // matches neither format
    localparam int STALL_PAIRS = (`ISSUE_BUF_DEPTH - `ISSUE_FULL_MARGIN) / 2;

    // note of a row, checked one edge after the row is applied
    localparam int N_NONE  = 0;
    localparam int N_DUAL  = 1;
    localparam int N_SOLO  = 2;
    localparam int N_FULL  = 3;
    localparam int N_DRAIN = 4;    // idle until the model queue is empty

    typedef struct {
        logic [1:0]  valid;
        logic        stall;
        logic        flush;
        int          note;
        logic [31:0] word_a;
        logic [31:0] word_b;
    } row_t;

    logic               clk;
    logic               rstn;
    logic               i_flush;
    logic               i_stall;
    logic [1:0]         i_inst_valid;
    logic [31:0]        i_inst_a;
    logic [31:0]        i_inst_b;
    logic [31:0]        i_pc_a;
    logic [31:0]        i_pc_b;
    logic               o_full;
    logic [1:0]         o_issue_valid;
    issue_entry_t       o_issue_a;
    issue_entry_t       o_issue_b;

    row_t               rows[$];
    issue_entry_t       model_q[$];    // decoded entries not yet issued
    logic [15:0]        lfsr_q;
    int                 cycles = 0;
    int                 limit = 0;
    int                 duals = 0;
    int                 solos = 0;

    issue_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_flush),
        .i_stall       (i_stall),
        .i_inst_valid  (i_inst_valid),
        .i_inst_a      (i_inst_a),
        .i_inst_b      (i_inst_b),
        .i_pc_a        (i_pc_a),
        .i_pc_b        (i_pc_b),
        .o_full        (o_full),
        .o_issue_valid (o_issue_valid),
        .o_issue_a     (o_issue_a),
        .o_issue_b     (o_issue_b)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // stimulus helpers
    function automatic logic [11:0] rand_bits(input int n);
        logic [11:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]; // x^16+x^14+x^13+x^11+1
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[10:0], fb};
        end
        return v;
    endfunction

    // writes r16..r31 and reads r0..r15, so never a hazard
    function automatic logic [31:0] rand_alu();
        logic [1:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] w;
        sel = 2'(rand_bits(2));
        rd  = {1'b1, 4'(rand_bits(4))};
        rj  = {1'b0, 4'(rand_bits(4))};
        rk  = {1'b0, 4'(rand_bits(4))};
        case (sel)
            2'd0:    w = {ADD_W, rk, rj, rd};
            2'd1:    w = {SUB_W, rk, rj, rd};
            2'd2:    w = {OR_R, rk, rj, rd};
            default: w = {ADDI_W, rand_bits(12), rj, rd};
        endcase
        return w;
    endfunction

    task automatic add_row(input logic [1:0] v, input logic st, input logic fl,
                           input int note, input logic [31:0] wa, input logic [31:0] wb);
        row_t r;
        r.valid  = v;
        r.stall  = st;
        r.flush  = fl;
        r.note   = note;
        r.word_a = wa;
        r.word_b = wb;
        rows.push_back(r);
    endtask

    task automatic add_idle(input int n, input logic st, input int note);
        for (int k = 0; k < n; k++) begin
            add_row(2'b00, st, 1'b0, (k == n - 1) ? note : N_NONE, 32'h0, 32'h0);
        end
    endtask

    //////////////////////////////
    // reference model
    function automatic issue_entry_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
        issue_entry_t e;
        e    = '0;
        e.pc = pc;
        e.rd = w[4:0];
        e.rj = w[9:5];
        case (w[31:15])
            ADD_W:   e.op = OP_ADD;
            SUB_W:   e.op = OP_SUB;
            AND_R:   e.op = OP_AND;
            OR_R:    e.op = OP_OR;
            default: e.op = OP_ILLEGAL;
        endcase
        if (e.op != OP_ILLEGAL) begin
            e.rk = w[14:10];
        end else begin
            case (w[31:22])
                ADDI_W:  e.op = OP_ADDI;
                LD_W:    e.op = OP_LD;
                ST_W:    e.op = OP_ST;
                default: e.op = OP_ILLEGAL;
            endcase
            if (e.op != OP_ILLEGAL) begin
                e.imm = {{20{w[21]}}, w[21:10]};   // si12 sign-extended
            end
        end
        e.lawful = (e.op != OP_ILLEGAL);
        e.is_mem = (e.op == OP_LD) || (e.op == OP_ST);
        e.rf_we  = e.lawful && (e.op != OP_ST);
        return e;
    endfunction

    // b may go with a unless it reads a's result or both touch memory
    function automatic logic pair_ok(input issue_entry_t a, input issue_entry_t b);
        logic hazard;
        hazard = a.rf_we && (a.rd != 5'd0) &&
                 ((b.rj == a.rd) || (b.rk == a.rd) || ((b.op == OP_ST) && (b.rd == a.rd)));
        return !hazard && !(a.is_mem && b.is_mem);
    endfunction

    //////////////////////////////
    // checks
    task automatic stop_fail(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_entry(input issue_entry_t got, input issue_entry_t exp,
                               input string what);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s entry %h, expected %h (pc %h)",
                                $time, what, got, exp, exp.pc));
        end
    endtask

    task automatic check_valid(input logic [1:0] got, input logic [1:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_full(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    // compare the pair issued at the last edge with the model queue head
    task automatic sample_issue(input logic was_stalled);
        issue_entry_t exp_a;
        issue_entry_t exp_b;
        int           need;
        need = int'(o_issue_valid[1]) + int'(o_issue_valid[0]);
        if (was_stalled) begin
            check_valid(o_issue_valid, 2'b00, "issue valid under stall");
        end else if (o_issue_valid == 2'b01) begin
            stop_fail("slot b issued while slot a was empty");
        end else if (model_q.size() < need) begin
            stop_fail($sformatf("DUT issued %0d entries at %0t with only %0d sent and pending",
                                need, $time, model_q.size()));
        end else if (need != 0) begin
            exp_a = model_q.pop_front();
            check_entry(o_issue_a, exp_a, "issued slot a");
            if (need == 2) begin
                exp_b = model_q.pop_front();
                check_entry(o_issue_b, exp_b, "issued slot b");
                if (!pair_ok(exp_a, exp_b)) begin
                    stop_fail("a dependent or double memory pair issued together");
                end
                duals++;
            end else begin
                solos++;
            end
        end
    endtask

    //////////////////////////////
    // stimulus table
    task automatic build_table();
        // every opcode once, the first pair is due three edges after it enters
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {ADD_W, 5'd2, 5'd1, 5'd3}, {SUB_W, 5'd6, 5'd5, 5'd4});
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {AND_R, 5'd9, 5'd8, 5'd7}, {OR_R, 5'd12, 5'd11, 5'd10});
        add_row(2'b11, 1'b0, 1'b0, N_DUAL,
                {ADDI_W, 12'hffb, 5'd14, 5'd13}, {LD_W, 12'h7f0, 5'd16, 5'd15});
        add_row(2'b10, 1'b0, 1'b0, N_NONE, {ST_W, 12'h800, 5'd18, 5'd17}, BAD_WORD);
        add_row(2'b11, 1'b0, 1'b0, N_NONE, BAD_WORD, {ADD_W, 5'd0, 5'd0, 5'd0});
        add_idle(1, 1'b0, N_DRAIN);

        for (int k = 0; k < 12; k++) begin
            add_row(2'b11, 1'b0, 1'b0, N_NONE, rand_alu(), rand_alu());
        end
        add_idle(1, 1'b0, N_DRAIN);

        // pairing, each case starts on an empty buffer
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {ADD_W, 5'd2, 5'd1, 5'd5}, {SUB_W, 5'd3, 5'd5, 5'd6});
        add_idle(2, 1'b0, N_SOLO);   // rj reads a's rd
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {AND_R, 5'd2, 5'd1, 5'd7}, {OR_R, 5'd7, 5'd2, 5'd8});
        add_idle(2, 1'b0, N_SOLO);   // rk reads a's rd
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {ADD_W, 5'd2, 5'd1, 5'd9}, {ST_W, 12'h008, 5'd4, 5'd9});
        add_idle(2, 1'b0, N_SOLO);   // store data is a's rd
        add_row(2'b11, 1'b0, 1'b0, N_NONE,
                {LD_W, 12'h004, 5'd1, 5'd10}, {ST_W, 12'h00c, 5'd2, 5'd11});
        add_idle(2, 1'b0, N_SOLO);
        add_row(2'b11, 1'b0, 1'b0, N_NONE, {ADD_W, 5'd2, 5'd1, 5'd0}, {SUB_W, 5'd0, 5'd0, 5'd3});
        add_idle(2, 1'b0, N_DUAL);   // r0 is never written
        add_row(2'b11, 1'b0, 1'b0, N_NONE,
                {ST_W, 12'h000, 5'd1, 5'd12}, {ADD_W, 5'd1, 5'd12, 5'd13});
        add_idle(2, 1'b0, N_DUAL);
        add_idle(1, 1'b0, N_DRAIN);

        // fill under stall up to the full level, then release
        for (int k = 0; k < STALL_PAIRS; k++) begin
            add_row(2'b11, 1'b1, 1'b0, N_NONE, rand_alu(), rand_alu());
        end
        add_idle(3, 1'b1, N_FULL);
        add_idle(1, 1'b0, N_DRAIN);

        // flush with pairs still in decode and buffer
        add_row(2'b11, 1'b0, 1'b0, N_NONE, rand_alu(), rand_alu());
        add_row(2'b11, 1'b0, 1'b0, N_NONE, rand_alu(), rand_alu());
        add_row(2'b00, 1'b0, 1'b1, N_NONE, 32'h0, 32'h0);
        add_row(2'b11, 1'b0, 1'b0, N_NONE, rand_alu(), rand_alu());
        add_idle(2, 1'b0, N_DUAL);
        add_idle(1, 1'b0, N_DRAIN);

        // flush of entries parked in the buffer by a stall
        for (int k = 0; k < 3; k++) begin
            add_row(2'b11, 1'b1, 1'b0, N_NONE, rand_alu(), rand_alu());
        end
        add_row(2'b00, 1'b1, 1'b1, N_NONE, 32'h0, 32'h0);
        add_row(2'b11, 1'b0, 1'b0, N_NONE, rand_alu(), rand_alu());
        add_idle(2, 1'b0, N_DUAL);
        add_idle(1, 1'b0, N_DRAIN);
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        rstn         = 1'b0;
        i_flush      = 1'b0;
        i_stall      = 1'b0;
        i_inst_valid = 2'b00;
        i_inst_a     = '0;
        i_inst_b     = '0;
        i_pc_a       = '0;
        i_pc_b       = '0;
        lfsr_q       = 16'd83;
        build_table();
        limit = rows.size() * 4 + 100;

        repeat (10) @(negedge clk);
        rstn = 1'b1;
        check_valid(o_issue_valid, 2'b00, "issue valid after reset");
        check_full(o_full, 1'b0, "full after reset");

        foreach (rows[i]) begin
            i_inst_valid = rows[i].valid;
            i_inst_a     = rows[i].word_a;
            i_inst_b     = rows[i].word_b;
            i_stall      = rows[i].stall;
            i_flush      = rows[i].flush;
            i_pc_a       = 32'h1c00_0000 + 32'(i * 8);
            i_pc_b       = i_pc_a + 32'd4;
            if (rows[i].flush) begin
                model_q.delete();    // everything older is dropped
            end else begin
                if (rows[i].valid[1]) begin
                    model_q.push_back(ref_decode(rows[i].word_a, i_pc_a));
                end
                if (rows[i].valid == 2'b11) begin
                    model_q.push_back(ref_decode(rows[i].word_b, i_pc_b));
                end
            end

            @(negedge clk);
            sample_issue(rows[i].stall);
            case (rows[i].note)
                N_DUAL:  check_valid(o_issue_valid, 2'b11, "issue valid of a free pair");
                N_SOLO:  check_valid(o_issue_valid, 2'b10, "issue valid of a blocked pair");
                N_FULL:  check_full(o_full, 1'b1, "full with a stalled buffer");
                N_DRAIN: begin
                    while (model_q.size() != 0) begin
                        @(negedge clk);
                        sample_issue(rows[i].stall);
                    end
                    @(negedge clk);
                    check_valid(o_issue_valid, 2'b00, "issue valid once drained");
                    check_full(o_full, 1'b0, "full once drained");
                end
                default: ;
            endcase
        end

        $display("%0d pairs and %0d single entries issued", duals, solos);
        $display("TEST PASS");
        $finish;
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            stop_fail($sformatf("timeout after %0d cycles, the issue stream stopped", cycles));
        end
    end

endmodule

/* hw/issue_top.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_top import issue_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  logic                   i_stall,
    input  logic [1:0]             i_inst_valid,
    input  logic [`ISSUE_XLEN-1:0] i_inst_a,
    input  logic [`ISSUE_XLEN-1:0] i_inst_b,
    input  logic [`ISSUE_XLEN-1:0] i_pc_a,
    input  logic [`ISSUE_XLEN-1:0] i_pc_b,
    output logic                   o_full,
    output logic [1:0]             o_issue_valid,
    output issue_entry_t           o_issue_a,
    output issue_entry_t           o_issue_b
);

    issue_entry_t head_a;
    issue_entry_t head_b;
    logic [1:0]   head_valid;
    logic [1:0]   using_num;

    dec_pair_if pair_if ();

    // decode, one cycle
    inst_decoder dec_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_inst_valid (i_inst_valid),
        .i_inst_a     (inst_word_u'(i_inst_a)),
        .i_inst_b     (inst_word_u'(i_inst_b)),
        .i_pc_a       (i_pc_a),
        .i_pc_b       (i_pc_b),
        .o_pair       (pair_if.src)
    );

    // issue buffer
    issue_buffer buf_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_flush      (i_flush),
        .i_pair       (pair_if.dst),
        .i_using_num  (using_num),
        .o_head_a     (head_a),
        .o_head_b     (head_b),
        .o_head_valid (head_valid),
        .o_full       (o_full)
    );

    // issue stage
    issue_select sel_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_flush),
        .i_stall       (i_stall),
        .i_head_a      (head_a),
        .i_head_b      (head_b),
        .i_head_valid  (head_valid),
        .o_using_num   (using_num),
        .o_issue_a     (o_issue_a),
        .o_issue_b     (o_issue_b),
        .o_issue_valid (o_issue_valid)
    );

endmodule

/* hw/issue_select.sv */
`timescale 1ns/1ps

module issue_select import issue_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_flush,
    input  logic         i_stall,
    input  issue_entry_t i_head_a,
    input  issue_entry_t i_head_b,
    input  logic [1:0]   i_head_valid,
    output logic [1:0]   o_using_num,
    output issue_entry_t o_issue_a,
    output issue_entry_t o_issue_b,
    output logic [1:0]   o_issue_valid
);

    logic a_writes;
    logic b_reads_rd;
    logic raw_hazard;
    logic both_mem;
    logic dual_ok;

    //////////////////////////////
    // pairing check
    assign a_writes   = i_head_a.rf_we && (i_head_a.rd != 5'd0);   // r0 never written
    assign b_reads_rd = (i_head_b.op == OP_ST);

    assign raw_hazard = a_writes &&
                        ((i_head_b.rj == i_head_a.rd) ||
                         (i_head_b.rk == i_head_a.rd) ||
                         (b_reads_rd && (i_head_b.rd == i_head_a.rd)));

    assign both_mem = i_head_a.is_mem && i_head_b.is_mem;   // one memory port
    assign dual_ok  = (i_head_valid == 2'b11) && !raw_hazard && !both_mem;

    always_comb begin
        if (i_stall || !i_head_valid[1]) begin
            o_using_num = 2'd0;
        end else if (dual_ok) begin
            o_using_num = 2'd2;
        end else begin
            o_using_num = 2'd1;   // b waits a cycle
        end
    end

    //////////////////////////////
    // issued pair
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_issue_valid <= 2'b00;
        end else if (i_flush) begin
            o_issue_valid <= 2'b00;
        end else begin
            o_issue_valid <= {o_using_num != 2'd0, o_using_num == 2'd2};
        end
    end

    always_ff @(posedge clk) begin
        if (o_using_num != 2'd0) begin
            o_issue_a <= i_head_a;
            o_issue_b <= i_head_b;    // only meaningful with valid 11
        end
    end

    // the buffer never offers slot b without slot a
    a_head_valid_code: assert property (
        @(posedge clk) disable iff (!rstn)
        i_head_valid != 2'b01
    ) else $error("head_valid is 01");

endmodule

/* hw/issue_buffer.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module issue_buffer import issue_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         i_flush,
    dec_pair_if.dst      i_pair,
    input  logic [1:0]   i_using_num,
    output issue_entry_t o_head_a,
    output issue_entry_t o_head_b,
    output logic [1:0]   o_head_valid,
    output logic         o_full
);

    localparam int DEPTH      = `ISSUE_BUF_DEPTH;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int FULL_LEVEL = DEPTH - `ISSUE_FULL_MARGIN;

    issue_entry_t buf_mem [DEPTH];

    // pointers carry one extra wrap bit, so head - tail is the occupancy
    logic [IDX_W:0]   head_q;   // next slot to write
    logic [IDX_W:0]   tail_q;   // oldest entry, next to issue
    logic [IDX_W:0]   occ;
    logic [IDX_W:0]   next_occ;
    logic [1:0]       add_num;
    logic [IDX_W-1:0] wr_idx0;
    logic [IDX_W-1:0] wr_idx1;
    logic [IDX_W-1:0] rd_idx0;
    logic [IDX_W-1:0] rd_idx1;

    //////////////////////////////
    // pointer arithmetic
    always_comb begin
        case (i_pair.valid)
            2'b10:   add_num = 2'd1;
            2'b11:   add_num = 2'd2;
            default: add_num = 2'd0;
        endcase
    end

    assign wr_idx0 = head_q[IDX_W-1:0];
    assign wr_idx1 = wr_idx0 + 1'b1;    // wraps at depth
    assign rd_idx0 = tail_q[IDX_W-1:0];
    assign rd_idx1 = rd_idx0 + 1'b1;

    assign occ      = head_q - tail_q;
    assign next_occ = occ + (IDX_W+1)'(add_num) - (IDX_W+1)'(i_using_num);

    //////////////////////////////
    // storage
    always_ff @(posedge clk) begin
        if (i_pair.valid[1]) begin
            buf_mem[wr_idx0] <= i_pair.entry_a;
        end
        if (i_pair.valid == 2'b11) begin
            buf_mem[wr_idx1] <= i_pair.entry_b;
        end
    end

    // heads always come from the tail, head_valid says how many count
    assign o_head_a = buf_mem[rd_idx0];
    assign o_head_b = buf_mem[rd_idx1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (i_flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + (IDX_W+1)'(add_num);
            tail_q <= tail_q + (IDX_W+1)'(i_using_num); // select holds 0 on stall
        end
    end

    //////////////////////////////
    // status, from occupancy after this cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else if (i_flush) begin
            o_head_valid <= 2'b00;
            o_full       <= 1'b0;
        end else begin
            if (next_occ == '0) begin
                o_head_valid <= 2'b00;
            end else if (next_occ == (IDX_W+1)'(1)) begin
                o_head_valid <= 2'b10;
            end else begin
                o_head_valid <= 2'b11;
            end
            o_full <= (next_occ >= (IDX_W+1)'(FULL_LEVEL)); // source stops on this
        end
    end

    // the full margin must keep writes from overrunning the tail
    a_occ_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        occ <= (IDX_W+1)'(DEPTH)
    ) else $error("issue buffer overflow");

    // select may only retire what head_valid advertised
    a_using_heads: assert property (
        @(posedge clk) disable iff (!rstn || i_flush)
        i_using_num <= ({1'b0, o_head_valid[1]} + {1'b0, o_head_valid[0]})
    ) else $error("using_num exceeds valid heads");

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/1ps
`include "issue_macros.svh"

module inst_decoder import issue_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_flush,
    input  logic [1:0]             i_inst_valid,
    input  inst_word_u             i_inst_a,
    input  inst_word_u             i_inst_b,
    input  logic [`ISSUE_XLEN-1:0] i_pc_a,
    input  logic [`ISSUE_XLEN-1:0] i_pc_b,
    dec_pair_if.src                o_pair
);

    issue_entry_t dec_a;
    issue_entry_t dec_b;

    //////////////////////////////
    // slot decode
    function automatic issue_entry_t decode_slot(
        input inst_word_u             word,
        input logic [`ISSUE_XLEN-1:0] pc
    );
        issue_entry_t e;
        logic         has_rk;
        logic         has_si12;
        e        = '0;
        e.pc     = pc;
        e.op     = OP_ILLEGAL;
        e.rd     = word.fmt_3r.rd;  // rd and rj share bits in both views
        e.rj     = word.fmt_3r.rj;
        has_rk   = 1'b1;
        has_si12 = 1'b0;

        // 3r first, its opcodes all start with ten zero bits
        case (word.fmt_3r.opcode)
            OPC_ADD_W: e.op = OP_ADD;
            OPC_SUB_W: e.op = OP_SUB;
            OPC_AND:   e.op = OP_AND;
            OPC_OR:    e.op = OP_OR;
            default: begin
                has_rk   = 1'b0;
                has_si12 = 1'b1;
                case (word.fmt_2ri12.opcode)
                    OPC_ADDI_W: e.op = OP_ADDI;
                    OPC_LD_W:   e.op = OP_LD;
                    OPC_ST_W:   e.op = OP_ST;
                    default:    has_si12 = 1'b0; // unknown, rk and imm stay zero
                endcase
            end
        endcase

        if (has_rk) begin
            e.rk = word.fmt_3r.rk;
        end
        if (has_si12) begin
            e.imm = {{(`ISSUE_XLEN-12){word.fmt_2ri12.si12[11]}}, word.fmt_2ri12.si12};
        end

        e.lawful = (e.op != OP_ILLEGAL);
        e.is_mem = (e.op == OP_LD) || (e.op == OP_ST);
        // st.w only reads rd, r0 handling is left to issue
        e.rf_we  = e.lawful && (e.op != OP_ST);
        return e;
    endfunction

    assign dec_a = decode_slot(i_inst_a, i_pc_a);
    assign dec_b = decode_slot(i_inst_b, i_pc_b);

    //////////////////////////////
    // pipeline register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_pair.valid <= 2'b00;
        end else if (i_flush) begin
            o_pair.valid <= 2'b00;  // drop the pair in flight
        end else begin
            o_pair.valid <= i_inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_pair.entry_a <= dec_a;
        o_pair.entry_b <= dec_b;
    end

    // fetch never hands over slot b without slot a
    a_no_lone_b: assert property (
        @(posedge clk) disable iff (!rstn)
        o_pair.valid != 2'b01
    ) else $error("decoded pair valid is 01");

endmodule

/* hw/dec_pair_if.sv */
`timescale 1ns/1ps

interface dec_pair_if import issue_pkg::*; ();

    issue_entry_t entry_a;
    issue_entry_t entry_b;
    logic [1:0]   valid;    // bit 1 is slot a, 01 never occurs

    // decode stage side
    modport src (
        output entry_a,
        output entry_b,
        output valid
    );

    // buffer side, strobe only
    modport dst (
        input entry_a,
        input entry_b,
        input valid
    );

endinterface

/* hw/issue_pkg.sv */
`include "issue_macros.svh"

package issue_pkg;

    // decoded operation
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_ADDI,
        OP_LD,
        OP_ST,
        OP_ILLEGAL
    } op_e;

    //////////////////////////////
    // major opcodes
    localparam logic [16:0] OPC_ADD_W  = 17'h00020; // 3r format, bits 31:15
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;   // 2ri12 format, bits 31:22
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;

    //////////////////////////////
    // instruction word, two views
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
    } inst_word_u;

    // one decoded slot, 86 bits
    typedef struct packed {
        logic [`ISSUE_XLEN-1:0] pc;
        op_e                    op;
        logic [4:0]             rd;      // st.w data source
        logic [4:0]             rj;
        logic [4:0]             rk;
        logic [`ISSUE_XLEN-1:0] imm;     // sign-extended si12
        logic                   rf_we;
        logic                   is_mem;
        logic                   lawful;
    } issue_entry_t;

endpackage

/* include/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// issue buffer geometry, depth kept a power of two
`define ISSUE_BUF_DEPTH   16

// slots held back for pairs still in decode or on the input
`define ISSUE_FULL_MARGIN 6

// data, pc and instruction word width
`define ISSUE_XLEN        32

`endif
